// File: logic/alu_consts.svh
/* Widths are fixed by the 32-bit opcode map; changing them is not supported.
   Only the low ALU_SHAMT_W bits of a shift amount are used. */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Operand width of a and b, result is twice this
`define ALU_WIDTH 32

// Low bits of b taken as the shift amount
`define ALU_SHAMT_W 5

// Steps of the multiplier and the divider
// One step per operand bit
`define ALU_ITERS 32

`endif

// File: logic/alu_pkg.sv
/* Shared ALU types. Select codes carry flag bits that the datapath reads
   directly, so their values must not be renumbered. */
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

	// Instruction-set opcodes, codes not listed here are illegal
	typedef enum logic [4:0] {
		OP_ADD  = 5'd3,
		OP_SUB  = 5'd4,
		OP_SHR  = 5'd5,
		OP_SHRA = 5'd6,
		OP_SHL  = 5'd7,
		OP_ROR  = 5'd8,
		OP_ROL  = 5'd9,
		OP_AND  = 5'd10,
		OP_OR   = 5'd11,
		OP_ADDI = 5'd12,
		OP_ANDI = 5'd13,
		OP_ORI  = 5'd14,
		OP_MUL  = 5'd15,
		OP_DIV  = 5'd16,
		OP_NEG  = 5'd17,
		OP_NOT  = 5'd18
	} spec_op_e;

	// Internal select codes
	// Arithmetic group 001xx: bit 0 subtract, bit 1 negate
	// Shift group 11xxx: bit 0 right, bit 1 rotate, bit 2 arithmetic
	typedef enum logic [4:0] {
		SEL_ILLEGAL = 5'b00000,
		SEL_NOT     = 5'b00001,
		SEL_AND     = 5'b00010,
		SEL_OR      = 5'b00011,
		SEL_ADD     = 5'b00100,
		SEL_SUB     = 5'b00101,
		SEL_NEG     = 5'b00111,
		SEL_MUL     = 5'b01000,
		SEL_DIV     = 5'b01001,
		SEL_SHL     = 5'b11000,
		SEL_SHR     = 5'b11001,
		SEL_ROL     = 5'b11010,
		SEL_ROR     = 5'b11011,
		SEL_SHRA    = 5'b11101
	} alu_sel_e;

	// Request from the bus
	typedef struct packed {
		spec_op_e               op;
		logic [`ALU_WIDTH-1:0] a;
		logic [`ALU_WIDTH-1:0] b;
	} alu_req_t;

	// Shifter direction and fill mode
	typedef struct packed {
		logic right;
		logic rotate;
		logic arith;
	} shift_ctrl_t;

	// Result halves
	// MUL gives hi:lo product, DIV gives remainder:quotient
	typedef struct packed {
		logic [`ALU_WIDTH-1:0] hi;
		logic [`ALU_WIDTH-1:0] lo;
	} alu_res_t;

endpackage

`default_nettype wire

// File: logic/alu_cla_adder.sv
/* Combinational 32-bit adder, no carry out. Width must be a multiple of 4. */
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_cla_adder (
	input  logic [`ALU_WIDTH-1:0] x,
	input  logic [`ALU_WIDTH-1:0] y,
	input  logic                  sub,
	output logic [`ALU_WIDTH-1:0] sum
);

	localparam int W = `ALU_WIDTH;
	localparam int GROUPS = W / 4;

	logic [W-1:0]      y_eff;
	logic [W-1:0]      gen;
	logic [W-1:0]      prop;
	logic [W-1:0]      carry;
	logic [GROUPS-1:0] grp_g;
	logic [GROUPS-1:0] grp_p;
	logic [GROUPS-1:0] grp_c;

	always_comb begin
		logic c_acc;
		logic p_run;
		// Two's complement subtract: invert y, carry in of one
		y_eff = sub ? ~y : y;
		gen = x & y_eff;
		prop = x ^ y_eff;

		// Group generate and propagate over 4 bits
		for (int k = 0; k < GROUPS; k++) begin
			grp_g[k] = gen[4*k+3]
				| (prop[4*k+3] & gen[4*k+2])
				| (prop[4*k+3] & prop[4*k+2] & gen[4*k+1])
				| (&prop[4*k+1 +: 3] & gen[4*k]);
			grp_p[k] = &prop[4*k +: 4];
		end

		// Second level, carry into each group as a flat sum of products
		grp_c[0] = sub;
		for (int k = 1; k < GROUPS; k++) begin
			c_acc = 1'b0;
			p_run = 1'b1;
			for (int j = k - 1; j >= 0; j--) begin
				c_acc = c_acc | (p_run & grp_g[j]);
				p_run = p_run & grp_p[j];
			end
			grp_c[k] = c_acc | (p_run & sub);
		end

		// Bit carries inside each group
		for (int k = 0; k < GROUPS; k++) begin
			carry[4*k] = grp_c[k];
			for (int j = 1; j < 4; j++) begin
				carry[4*k+j] = gen[4*k+j-1] | (prop[4*k+j-1] & carry[4*k+j-1]);
			end
		end

		sum = prop ^ carry;
	end

endmodule

`default_nettype wire

// File: logic/alu_shifter.sv
/* Combinational barrel shifter. Arithmetic fill applies to right shifts only,
   shift amounts wrap at the word width. */
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_shifter
	import alu_pkg::*;
(
	input  logic [`ALU_WIDTH-1:0]   value,
	input  logic [`ALU_SHAMT_W-1:0] shamt,
	input  shift_ctrl_t             ctrl,
	output logic [`ALU_WIDTH-1:0]   shifted
);

	localparam int W = `ALU_WIDTH;
	localparam int SH = `ALU_SHAMT_W;

	// stage[SH] is the input, stage[0] the output
	logic [SH:0][W-1:0] stage;

	// One fixed-distance step, n is never zero
	function automatic logic [W-1:0] shift_step(
		input logic [W-1:0] v,
		input int           n,
		input shift_ctrl_t  c
	);
		logic [W-1:0] fill;
		if (c.right) begin
			// Vacated high bits
			if (c.rotate)
				fill = v << (W - n);
			else if (c.arith)
				fill = {W{v[W-1]}} << (W - n);
			else
				fill = '0;
			shift_step = (v >> n) | fill;
		end else begin
			// Vacated low bits, wrapped only for rotate
			fill = c.rotate ? (v >> (W - n)) : '0;
			shift_step = (v << n) | fill;
		end
	endfunction

	// Stages by 16, 8, 4, 2, 1 under the matching shamt bit
	always_comb begin
		stage[SH] = value;
		for (int s = SH - 1; s >= 0; s--) begin
			stage[s] = shamt[s] ? shift_step(stage[s+1], 1 << s, ctrl) : stage[s+1];
		end
	end

	assign shifted = stage[0];

endmodule

`default_nettype wire

// File: logic/alu_multiplier.sv
/* Signed 32x32 multiplier, done 33 cycles after go. Operands must stay stable
   on the go cycle only; go is ignored while running. */
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_multiplier
	import alu_pkg::*;
(
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  go,
	input  logic [`ALU_WIDTH-1:0] a,
	input  logic [`ALU_WIDTH-1:0] b,
	output alu_res_t              product,
	output logic                  done
);

	localparam int W = `ALU_WIDTH;
	localparam int CNT_W = $clog2(`ALU_ITERS);

	typedef enum logic [1:0] {
		MUL_IDLE,
		MUL_RUN,
		MUL_FIX
	} mul_state_e;

	mul_state_e     state;
	logic [CNT_W-1:0] cnt;
	logic [W-1:0]   a_mag;
	logic [W-1:0]   b_mag;
	logic [W-1:0]   mcand;
	logic [2*W-1:0] acc;
	logic [W:0]     part_sum;
	logic           neg;

	// Magnitudes, the most negative value maps to 2^31 unsigned
	assign a_mag = a[W-1] ? -a : a;
	assign b_mag = b[W-1] ? -b : b;

	// Upper half plus multiplicand when the current multiplier bit is set
	assign part_sum = {1'b0, acc[2*W-1:W]} + (acc[0] ? {1'b0, mcand} : '0);

	// Sequencing
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= MUL_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				MUL_IDLE: begin
					if (go) begin
						cnt <= CNT_W'(`ALU_ITERS - 1);
						state <= MUL_RUN;
					end
				end
				MUL_RUN: begin
					// Last step moves on to sign correction
					if (cnt == '0)
						state <= MUL_FIX;
					else
						cnt <= cnt - 1'b1;
				end
				default: state <= MUL_IDLE;
			endcase
		end
	end

	// Datapath
	always_ff @(posedge clock) begin
		if (state == MUL_IDLE && go) begin
			mcand <= a_mag;
			// Multiplier sits in the low half and shifts out bit by bit
			acc <= {{W{1'b0}}, b_mag};
			neg <= a[W-1] ^ b[W-1];
		end else if (state == MUL_RUN) begin
			acc <= {part_sum, acc[W-1:1]};
		end
	end

	// Sign applied on the output, valid during the fix cycle
	assign product = neg ? -acc : acc;
	assign done = (state == MUL_FIX);

endmodule

`default_nettype wire

// File: logic/alu_divider.sv
/* Signed 32-bit restoring divider, done 33 cycles after go. Quotient truncates
   toward zero; divide by zero gives all ones and the dividend as remainder. */
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu_divider
	import alu_pkg::*;
(
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  go,
	input  logic [`ALU_WIDTH-1:0] a,
	input  logic [`ALU_WIDTH-1:0] b,
	output alu_res_t              quot_rem,
	output logic                  done
);

	localparam int W = `ALU_WIDTH;
	localparam int CNT_W = $clog2(`ALU_ITERS);

	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_FIX
	} div_state_e;

	div_state_e       state;
	logic [CNT_W-1:0] cnt;
	logic [W-1:0]     a_mag;
	logic [W-1:0]     b_mag;
	logic [W-1:0]     den;
	logic [W-1:0]     quo;
	logic [W-1:0]     rem;
	logic [W:0]       rem_shift;
	logic [W:0]       trial;
	logic             neg_quo;
	logic             neg_rem;

	assign a_mag = a[W-1] ? -a : a;
	assign b_mag = b[W-1] ? -b : b;

	// Next dividend bit enters the partial remainder
	assign rem_shift = {rem, quo[W-1]};
	// Trial subtraction, top bit set means the divisor did not fit
	assign trial = rem_shift - {1'b0, den};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= DIV_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				DIV_IDLE: begin
					if (go) begin
						cnt <= CNT_W'(`ALU_ITERS - 1);
						state <= DIV_RUN;
					end
				end
				DIV_RUN: begin
					if (cnt == '0)
						state <= DIV_FIX;
					else
						cnt <= cnt - 1'b1;
				end
				default: state <= DIV_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == DIV_IDLE && go) begin
			den <= b_mag;
			// Dividend shifts out of quo while quotient bits shift in
			quo <= a_mag;
			rem <= '0;
			// Zero divisor keeps the all ones quotient unsigned
			neg_quo <= (a[W-1] ^ b[W-1]) && (b != '0);
			neg_rem <= a[W-1];
		end else if (state == DIV_RUN) begin
			if (!trial[W]) begin
				rem <= trial[W-1:0];
				quo <= {quo[W-2:0], 1'b1};
			end else begin
				// Restore, keep the shifted remainder
				rem <= rem_shift[W-1:0];
				quo <= {quo[W-2:0], 1'b0};
			end
		end
	end

	// Remainder follows the dividend sign
	assign quot_rem.hi = neg_rem ? -rem : rem;
	assign quot_rem.lo = neg_quo ? -quo : quo;
	assign done = (state == DIV_FIX);

endmodule

`default_nettype wire

// File: logic/alu.sv
/* ALU top. One operation at a time, a start while busy is dropped. The result
   and illegal flag hold until the next operation finishes. */
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module alu
	import alu_pkg::*;
(
	input  logic     clock,
	input  logic     arst_n,
	input  logic     start,
	input  alu_req_t req,
	output logic     busy,
	output logic     finished,
	output logic     illegal,
	output alu_res_t result
);

	localparam int W = `ALU_WIDTH;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FAST,
		ST_WAIT_SEQ
	} ctrl_state_e;

	ctrl_state_e state;
	alu_sel_e    dec_sel;
	alu_sel_e    sel_q;
	logic [W-1:0] a_q;
	logic [W-1:0] b_q;
	logic        accept;
	logic        dec_seq;
	logic [W-1:0] add_x;
	logic [W-1:0] add_y;
	logic [W-1:0] add_sum;
	logic [W-1:0] shift_out;
	shift_ctrl_t shift_ctrl;
	logic        mul_go;
	logic        mul_done;
	logic        div_go;
	logic        div_done;
	logic        seq_done;
	alu_res_t    mul_res;
	alu_res_t    div_res;
	alu_res_t    seq_res;
	alu_res_t    fast_res;

	// Opcode recode, immediates share the register forms
	always_comb begin
		case (req.op)
			OP_ADD, OP_ADDI: dec_sel = SEL_ADD;
			OP_SUB:          dec_sel = SEL_SUB;
			OP_NEG:          dec_sel = SEL_NEG;
			OP_AND, OP_ANDI: dec_sel = SEL_AND;
			OP_OR, OP_ORI:   dec_sel = SEL_OR;
			OP_NOT:          dec_sel = SEL_NOT;
			OP_SHL:          dec_sel = SEL_SHL;
			OP_SHR:          dec_sel = SEL_SHR;
			OP_SHRA:         dec_sel = SEL_SHRA;
			OP_ROL:          dec_sel = SEL_ROL;
			OP_ROR:          dec_sel = SEL_ROR;
			OP_MUL:          dec_sel = SEL_MUL;
			OP_DIV:          dec_sel = SEL_DIV;
			default:         dec_sel = SEL_ILLEGAL;
		endcase
	end

	assign dec_seq = (dec_sel == SEL_MUL) || (dec_sel == SEL_DIV);
	assign busy = (state != ST_IDLE);
	assign accept = start && !busy;

	// Operand capture, later bus changes do not reach the units
	always_ff @(posedge clock) begin
		if (accept) begin
			a_q <= req.a;
			b_q <= req.b;
		end
	end

	// Negate runs as 0 - a
	assign add_x = sel_q[1] ? '0 : a_q;
	assign add_y = sel_q[1] ? a_q : b_q;

	alu_cla_adder u_adder (
		.x   (add_x),
		.y   (add_y),
		.sub (sel_q[0]),
		.sum (add_sum)
	);

	// Shift flags straight from the select code
	always_comb begin
		shift_ctrl.right = sel_q[0];
		shift_ctrl.rotate = sel_q[1];
		shift_ctrl.arith = sel_q[2];
	end

	alu_shifter u_shifter (
		.value   (a_q),
		.shamt   (b_q[`ALU_SHAMT_W-1:0]),
		.ctrl    (shift_ctrl),
		.shifted (shift_out)
	);

	alu_multiplier u_mul (
		.clock   (clock),
		.arst_n  (arst_n),
		.go      (mul_go),
		.a       (a_q),
		.b       (b_q),
		.product (mul_res),
		.done    (mul_done)
	);

	alu_divider u_div (
		.clock    (clock),
		.arst_n   (arst_n),
		.go       (div_go),
		.a        (a_q),
		.b        (b_q),
		.quot_rem (div_res),
		.done     (div_done)
	);

	// Single-cycle result, upper half always zero
	always_comb begin
		fast_res = '0;
		case (sel_q)
			SEL_NOT:                   fast_res.lo = ~a_q;
			SEL_AND:                   fast_res.lo = a_q & b_q;
			SEL_OR:                    fast_res.lo = a_q | b_q;
			SEL_ADD, SEL_SUB, SEL_NEG: fast_res.lo = add_sum;
			SEL_SHL, SEL_SHR, SEL_ROL, SEL_ROR, SEL_SHRA: fast_res.lo = shift_out;
			default:                   fast_res.lo = '0;
		endcase
	end

	// Bit 0 tells DIV from MUL
	assign seq_done = sel_q[0] ? div_done : mul_done;
	assign seq_res = sel_q[0] ? div_res : mul_res;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			sel_q <= SEL_ILLEGAL;
			mul_go <= 1'b0;
			div_go <= 1'b0;
			finished <= 1'b0;
			illegal <= 1'b0;
			result <= '0;
		end else begin
			// Pulses last one cycle
			finished <= 1'b0;
			mul_go <= 1'b0;
			div_go <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						sel_q <= dec_sel;
						if (dec_seq) begin
							mul_go <= (dec_sel == SEL_MUL);
							div_go <= (dec_sel == SEL_DIV);
							state <= ST_WAIT_SEQ;
						end else begin
							state <= ST_FAST;
						end
					end
				end
				ST_FAST: begin
					result <= fast_res;
					illegal <= (sel_q == SEL_ILLEGAL);
					finished <= 1'b1;
					state <= ST_IDLE;
				end
				ST_WAIT_SEQ: begin
					// Unit holds its output during its done cycle
					if (seq_done) begin
						result <= seq_res;
						illegal <= 1'b0;
						finished <= 1'b1;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: tb/alu_chk.sv
/* Handshake and result-hold assertions for the ALU top, bound to every alu
   instance. Nothing is checked while arst_n is low. */
`timescale 1ns/1ps
`default_nettype none

module alu_chk
	import alu_pkg::*;
(
	input logic     clock,
	input logic     arst_n,
	input logic     start,
	input logic     busy,
	input logic     finished,
	input alu_res_t result
);

	// finished is a single-cycle pulse
	a_finished_pulse: assert property (@(posedge clock) disable iff (!arst_n)
		finished |=> !finished)
		else $error("finished high on two cycles in a row");

	// busy ends on the edge that raises finished, and only then
	a_busy_fall: assert property (@(posedge clock) disable iff (!arst_n)
		$fell(busy) |-> $rose(finished))
		else $error("busy fell without finished");
	a_finish_rise: assert property (@(posedge clock) disable iff (!arst_n)
		$rose(finished) |-> $fell(busy))
		else $error("finished rose while busy stayed high");

	// Result moves only with a finished pulse
	a_result_hold: assert property (@(posedge clock) disable iff (!arst_n)
		$changed(result) |-> $rose(finished))
		else $error("result changed outside a finished pulse");

	// Accepted start
	a_accept_busy: assert property (@(posedge clock) disable iff (!arst_n)
		start && !busy |=> busy)
		else $error("accepted start did not raise busy");

endmodule

bind alu alu_chk u_chk (
	.clock    (clock),
	.arst_n   (arst_n),
	.start    (start),
	.busy     (busy),
	.finished (finished),
	.result   (result)
);

`default_nettype wire

// File: tb/tb_alu.sv
/* Directed ALU testbench with a behavioral model. LFSR operands use a fixed
   seed. The watchdog limit assumes about 40 cycles per operation at most. */
`timescale 1ns/1ps
`default_nettype none

`include "alu_consts.svh"

module tb_alu
	import alu_pkg::*;
();

	localparam int W = `ALU_WIDTH;
	localparam int RESET_CYCLES = 5;
	// Operations per test in the order logic, arith, shift, mul, div, control and reset
	localparam int NUM_OPS = 25 + 23 + 40 + 12 + 12 + 7 + 1;
	localparam int CYCLE_LIMIT = NUM_OPS * 40 + RESET_CYCLES;

	logic        clock;
	logic        arst_n;
	logic        start;
	alu_req_t    req;
	logic        busy;
	logic        finished;
	logic        illegal;
	alu_res_t    result;
	logic [31:0] lfsr;
	int          cycles = 0;
	int          checks = 0;
	int          errors = 0;

	alu uut (
		.clock    (clock),
		.arst_n   (arst_n),
		.start    (start),
		.req      (req),
		.busy     (busy),
		.finished (finished),
		.illegal  (illegal),
		.result   (result)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// Watchdog over the whole run
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_word(output logic [W-1:0] w);
		w = '0;
		for (int i = 0; i < W; i++) begin
			lfsr = lfsr_next(lfsr);
			w = {w[W-2:0], lfsr[0]};
		end
	endtask

	// Reference model from the opcode rules
	function automatic alu_res_t expected_result(input spec_op_e op, input logic [W-1:0] a,
			input logic [W-1:0] b, output logic bad);
		logic [2*W-1:0]        both;
		logic signed [2*W-1:0] sa;
		logic signed [2*W-1:0] sb;
		logic [4:0]            amt;
		alu_res_t              r;
		amt = b[4:0];
		both = {a, a};
		sa = $signed(a);
		sb = $signed(b);
		r = '0;
		bad = 1'b0;
		case (op)
			OP_ADD, OP_ADDI: r.lo = a + b;
			OP_SUB:          r.lo = a - b;
			OP_NEG:          r.lo = -a;
			OP_AND, OP_ANDI: r.lo = a & b;
			OP_OR, OP_ORI:   r.lo = a | b;
			OP_NOT:          r.lo = ~a;
			OP_SHL:          r.lo = a << amt;
			OP_SHR:          r.lo = a >> amt;
			OP_SHRA:         r.lo = $signed(a) >>> amt;
			// Rotates through a doubled word
			OP_ROL: begin
				both = both << amt;
				r.lo = both[2*W-1:W];
			end
			OP_ROR: begin
				both = both >> amt;
				r.lo = both[W-1:0];
			end
			OP_MUL:          r = sa * sb;
			OP_DIV: begin
				if (b == '0) begin
					r.hi = a;
					r.lo = '1;
				end else begin
					// 64-bit math keeps the most negative quotient exact
					r.hi = W'(sa % sb);
					r.lo = W'(sa / sb);
				end
			end
			default:         bad = 1'b1;
		endcase
		return r;
	endfunction

	task automatic check_value(input string name, input string what,
			input logic [63:0] exp_v, input logic [63:0] act_v);
		checks++;
		if (act_v !== exp_v) begin
			$display("ERROR %s %s: expected %h, actual %h", name, what, exp_v, act_v);
			errors++;
		end
	endtask

	// Issue one request and wait for finished, then compare result, illegal and latency
	task automatic run_op(input string name, input spec_op_e op, input logic [W-1:0] a,
			input logic [W-1:0] b);
		alu_res_t exp_res;
		logic     exp_bad;
		int       lat_exp;
		int       lat;
		exp_res = expected_result(op, a, b, exp_bad);
		lat_exp = (op == OP_MUL || op == OP_DIV) ? 34 : 1;
		@(posedge clock);
		start <= 1'b1;
		req <= '{op: op, a: a, b: b};
		@(posedge clock);
		start <= 1'b0;
		// Scrambled bus so only the captured copy gives the right answer
		req.a <= ~a;
		req.b <= ~b;
		lat = 0;
		while (!finished && lat < 40) begin
			@(posedge clock);
			lat++;
			@(negedge clock);
		end
		if (!finished) begin
			$display("%s: finished never rose after the request was accepted", name);
			checks++;
			errors++;
		end else begin
			check_value(name, "result", exp_res, result);
			check_value(name, "illegal", 64'(exp_bad), 64'(illegal));
			check_value(name, "latency", 64'(lat_exp), 64'(lat));
		end
	endtask

	task automatic report_test(input string name, input int err0, input int chk0);
		$display("Test %s done: %0d checks, %0d errors", name, checks - chk0, errors - err0);
	endtask

	task automatic test_reset();
		int e0;
		int c0;
		e0 = errors;
		c0 = checks;
		@(negedge clock);
		check_value("reset", "result", 64'd0, result);
		check_value("reset", "busy finished illegal", 64'd0, {busy, finished, illegal});
		report_test("reset", e0, c0);
	endtask

	task automatic test_logic();
		spec_op_e     ops [5] = '{OP_NOT, OP_AND, OP_OR, OP_ANDI, OP_ORI};
		logic [W-1:0] x;
		logic [W-1:0] y;
		int           e0;
		int           c0;
		e0 = errors;
		c0 = checks;
		foreach (ops[i]) begin
			run_op(ops[i].name(), ops[i], 32'hf0f0_a5a5, 32'h0ff0_3c3c);
			for (int n = 0; n < 4; n++) begin
				rand_word(x);
				rand_word(y);
				run_op(ops[i].name(), ops[i], x, y);
			end
		end
		report_test("logic", e0, c0);
	endtask

	task automatic test_arith();
		spec_op_e     ops [4] = '{OP_ADD, OP_ADDI, OP_SUB, OP_NEG};
		logic [W-1:0] x;
		logic [W-1:0] y;
		int           e0;
		int           c0;
		e0 = errors;
		c0 = checks;
		// Wraparound corners
		run_op("add wrap", OP_ADD, 32'h7fff_ffff, 32'h0000_0001);
		run_op("addi wrap", OP_ADDI, 32'hffff_ffff, 32'h0000_0001);
		run_op("sub borrow", OP_SUB, 32'h0000_0000, 32'h0000_0001);
		run_op("sub min", OP_SUB, 32'h8000_0000, 32'h0000_0001);
		run_op("neg zero", OP_NEG, 32'h0000_0000, 32'h1234_5678);
		run_op("neg min", OP_NEG, 32'h8000_0000, 32'h0);
		run_op("neg one", OP_NEG, 32'h0000_0001, 32'h0);
		foreach (ops[i]) begin
			for (int n = 0; n < 4; n++) begin
				rand_word(x);
				rand_word(y);
				run_op(ops[i].name(), ops[i], x, y);
			end
		end
		report_test("arith", e0, c0);
	endtask

	task automatic test_shift();
		spec_op_e     ops [5] = '{OP_SHL, OP_SHR, OP_SHRA, OP_ROL, OP_ROR};
		logic [W-1:0] amts [4] = '{32'd0, 32'd1, 32'd31, 32'hffff_ffe3};
		logic [W-1:0] x;
		logic [W-1:0] y;
		int           e0;
		int           c0;
		e0 = errors;
		c0 = checks;
		foreach (ops[i]) begin
			// Last fixed amount has high bits set and only 3 counts
			foreach (amts[k]) begin
				run_op(ops[i].name(), ops[i], 32'h8123_4567, amts[k]);
			end
			for (int n = 0; n < 4; n++) begin
				rand_word(x);
				rand_word(y);
				run_op(ops[i].name(), ops[i], x, y);
			end
		end
		report_test("shift", e0, c0);
	endtask

	task automatic test_mul();
		logic [W-1:0] x;
		logic [W-1:0] y;
		int           e0;
		int           c0;
		e0 = errors;
		c0 = checks;
		run_op("mul min squared", OP_MUL, 32'h8000_0000, 32'h8000_0000);
		run_op("mul neg pos", OP_MUL, 32'hffff_fffd, 32'd7);
		run_op("mul pos neg", OP_MUL, 32'd7, 32'hffff_fffd);
		run_op("mul neg neg", OP_MUL, 32'hffff_ffff, 32'hffff_ffff);
		run_op("mul zero", OP_MUL, 32'd0, 32'h1234_5678);
		run_op("mul max min", OP_MUL, 32'h7fff_ffff, 32'h8000_0000);
		for (int n = 0; n < 6; n++) begin
			rand_word(x);
			rand_word(y);
			run_op("mul random", OP_MUL, x, y);
		end
		report_test("mul", e0, c0);
	endtask

	task automatic test_div();
		logic [W-1:0] x;
		logic [W-1:0] y;
		int           e0;
		int           c0;
		e0 = errors;
		c0 = checks;
		// Truncation toward zero in every sign case
		run_op("div pos neg", OP_DIV, 32'd7, 32'hffff_fffe);
		run_op("div neg pos", OP_DIV, 32'hffff_fff9, 32'd2);
		run_op("div neg neg", OP_DIV, 32'hffff_fff9, 32'hffff_fffe);
		run_op("div zero pos", OP_DIV, 32'd100, 32'd0);
		run_op("div zero neg", OP_DIV, 32'hffff_ff9c, 32'd0);
		run_op("div min", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
		for (int n = 0; n < 6; n++) begin
			rand_word(x);
			rand_word(y);
			// Smaller divisors give quotients that are not just 0 or 1
			y = W'($signed(y) >>> 12);
			run_op("div random", OP_DIV, x, y);
		end
		report_test("div", e0, c0);
	endtask

	task automatic test_control();
		logic [4:0]   bad_codes [5] = '{5'd0, 5'd1, 5'd2, 5'd19, 5'd31};
		logic [W-1:0] x;
		logic [W-1:0] y;
		alu_res_t     exp_res;
		logic         exp_bad;
		int           pulses;
		int           e0;
		int           c0;
		e0 = errors;
		c0 = checks;
		foreach (bad_codes[i]) begin
			run_op("illegal", spec_op_e'(bad_codes[i]), 32'hdead_beef, 32'h0bad_f00d);
		end
		// MUL with a second start in the middle of its run
		rand_word(x);
		rand_word(y);
		exp_res = expected_result(OP_MUL, x, y, exp_bad);
		@(posedge clock);
		start <= 1'b1;
		req <= '{op: OP_MUL, a: x, b: y};
		@(posedge clock);
		start <= 1'b0;
		repeat (5) @(posedge clock);
		start <= 1'b1;
		req <= '{op: OP_ADD, a: 32'd1, b: 32'd2};
		@(posedge clock);
		start <= 1'b0;
		pulses = 0;
		repeat (45) begin
			@(negedge clock);
			if (finished) begin
				pulses++;
				check_value("busy start", "result", exp_res, result);
				check_value("busy start", "illegal", 64'(exp_bad), 64'(illegal));
			end
		end
		checks++;
		if (pulses != 1) begin
			$display("busy start: saw %0d finished pulses where exactly one was due", pulses);
			errors++;
		end
		report_test("control", e0, c0);
	endtask

	initial begin
		lfsr = 32'hc3c2a519;
		arst_n = 1'b0;
		start = 1'b0;
		req = '0;
		repeat (RESET_CYCLES) @(posedge clock);
		arst_n <= 1'b1;
		test_reset();
		test_logic();
		test_arith();
		test_shift();
		test_mul();
		test_div();
		test_control();
		$display("Totals: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
logic/alu_pkg.sv
logic/alu_cla_adder.sv
logic/alu_shifter.sv
logic/alu_multiplier.sv
logic/alu_divider.sv
logic/alu.sv
tb/alu_chk.sv
tb/tb_alu.sv

// File: Makefile
# Verilator build and run of the ALU testbench
# Any variable can be overridden, for example make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_alu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
